// ==== rv_isa_pkg.sv ====
// RV32I instruction set definitions
`default_nettype none

package rv_isa_pkg;

	// --------------------
	// widths and basic types

	localparam int XLEN      = 32;
	localparam int W_REGADDR = 5;

	typedef logic [31:0]          instr_t;
	typedef logic [W_REGADDR-1:0] reg_addr_t;

	// --------------------
	// major opcodes, taken from instruction bits 6:2

	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_e;

	// --------------------
	// funct3 and funct7 encodings

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load and store access sizes, the U forms exist for loads only
	localparam logic [2:0] F3_MEM_B  = 3'b000;
	localparam logic [2:0] F3_MEM_H  = 3'b001;
	localparam logic [2:0] F3_MEM_W  = 3'b010;
	localparam logic [2:0] F3_MEM_BU = 3'b100;
	localparam logic [2:0] F3_MEM_HU = 3'b101;

	// integer ALU operations, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_JALR  = 3'b000;
	localparam logic [2:0] F3_FENCE = 3'b000;

	// funct7 is either all zero or selects SUB/SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// --------------------
	// immediate formats, all sign extended to XLEN

	typedef struct packed {
		logic [XLEN-1:0] i;
		logic [XLEN-1:0] s;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] u;
		logic [XLEN-1:0] j;
	} imm_set_t;

endpackage

`default_nettype wire

// ==== decode_ctrl_pkg.sv ====
// Decode stage control types
`default_nettype none

package decode_ctrl_pkg;

	import rv_isa_pkg::*;

	// --------------------
	// execute stage controls

	typedef enum logic [3:0] {
		ALUOP_ADD = 4'h0,
		ALUOP_SUB = 4'h1,
		ALUOP_LT  = 4'h2,
		ALUOP_LTU = 4'h3,
		ALUOP_AND = 4'h4,
		ALUOP_OR  = 4'h5,
		ALUOP_XOR = 4'h6,
		ALUOP_SLL = 4'h7,
		ALUOP_SRL = 4'h8,
		ALUOP_SRA = 4'h9,
		// pass operand B straight through, used for LUI and store data
		ALUOP_RS2 = 4'ha
	} aluop_e;

	typedef enum logic {
		ALUSRCA_RS1 = 1'b0,
		ALUSRCA_PC  = 1'b1
	} alusrc_a_e;

	typedef enum logic {
		ALUSRCB_RS2 = 1'b0,
		ALUSRCB_IMM = 1'b1
	} alusrc_b_e;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'h0,
		MEMOP_LB   = 4'h1,
		MEMOP_LH   = 4'h2,
		MEMOP_LW   = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_LHU  = 4'h5,
		MEMOP_SB   = 4'h6,
		MEMOP_SH   = 4'h7,
		MEMOP_SW   = 4'h8
	} memop_e;

	// ZERO and NZERO test the ALU result of the branch compare
	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'h0,
		BCOND_ALWAYS = 2'h1,
		BCOND_ZERO   = 2'h2,
		BCOND_NZERO  = 2'h3
	} bcond_e;

	typedef enum logic [1:0] {
		EXCEPT_NONE          = 2'h0,
		EXCEPT_INSTR_ILLEGAL = 2'h1,
		EXCEPT_INSTR_FAULT   = 2'h2
	} except_e;

	// --------------------
	// current instruction register from fetch

	typedef struct packed {
		instr_t     instr;
		logic [1:0] vld;
		logic [1:0] err;
	} fetch_cir_t;

	// everything execute needs for one instruction
	typedef struct packed {
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
		logic [XLEN-1:0] imm;
		alusrc_a_e       alusrc_a;
		alusrc_b_e       alusrc_b;
		aluop_e          aluop;
		memop_e          memop;
		bcond_e          branchcond;
		logic [XLEN-1:0] addr_offs;
		logic            addr_is_regoffs;
		except_e         except;
		logic [2:0]      funct3;
	} d_ctrl_t;

endpackage

`default_nettype wire

// ==== imm_gen.sv ====
// Immediate generator
`timescale 1ns/1ps
`default_nettype none

module imm_gen
	import rv_isa_pkg::*;
(
	input  instr_t   instr_i,
	output imm_set_t imm_o
);

	// bit 31 of the instruction is always the sign bit
	logic sign;

	assign sign = instr_i[31];

	// I format: loads, JALR and OP-IMM
	assign imm_o.i = {{21{sign}}, instr_i[30:20]};

	// S format splits the offset around the rd field
	assign imm_o.s = {{21{sign}}, instr_i[30:25], instr_i[11:7]};

	// B format is a halfword offset, so bit 0 is always zero
	assign imm_o.b = {
		{20{sign}},
		instr_i[7],
		instr_i[30:25],
		instr_i[11:8],
		1'b0
	};

	// U format fills the upper twenty bits and leaves the rest clear
	assign imm_o.u = {instr_i[31:12], 12'h000};

	// J format, again a halfword offset
	assign imm_o.j = {
		{12{sign}},
		instr_i[19:12],
		instr_i[20],
		instr_i[30:21],
		1'b0
	};

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
// RV32I instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
(
	input  instr_t     instr_i,
	input  logic [1:0] err_i,
	input  logic       starved_i,
	input  imm_set_t   imm_i,
	output d_ctrl_t    ctrl_o
);

	localparam reg_addr_t X0 = '0;

	opcode_e    opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       fault;
	logic       illegal;

	assign opc = opcode_e'(instr_i[6:2]);
	assign f3  = instr_i[14:12];
	assign f7  = instr_i[31:25];

	// a bus error on either halfword poisons the whole 32-bit word
	assign fault = !starved_i && |err_i;

	// --------------------
	// opcode table

	always_comb begin
		ctrl_o.rs1             = instr_i[19:15];
		ctrl_o.rs2             = instr_i[24:20];
		ctrl_o.rd              = instr_i[11:7];
		ctrl_o.imm             = imm_i.i;
		ctrl_o.alusrc_a        = ALUSRCA_RS1;
		ctrl_o.alusrc_b        = ALUSRCB_RS2;
		ctrl_o.aluop           = ALUOP_ADD;
		ctrl_o.memop           = MEMOP_NONE;
		ctrl_o.branchcond      = BCOND_NEVER;
		ctrl_o.addr_is_regoffs = 1'b0;
		ctrl_o.except          = EXCEPT_NONE;
		ctrl_o.funct3          = f3;
		// low bits other than 11 would mean a compressed or longer encoding
		illegal = instr_i[1:0] != 2'b11;

		case (opc)
			OPC_LOAD: begin
				ctrl_o.rs2 = X0;
				ctrl_o.addr_is_regoffs = 1'b1;
				case (f3)
					F3_MEM_B:  ctrl_o.memop = MEMOP_LB;
					F3_MEM_H:  ctrl_o.memop = MEMOP_LH;
					F3_MEM_W:  ctrl_o.memop = MEMOP_LW;
					F3_MEM_BU: ctrl_o.memop = MEMOP_LBU;
					F3_MEM_HU: ctrl_o.memop = MEMOP_LHU;
					default:   illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				ctrl_o.rd = X0;
				ctrl_o.addr_is_regoffs = 1'b1;
				// the ALU carries the store data through from rs2
				ctrl_o.aluop = ALUOP_RS2;
				case (f3)
					F3_MEM_B: ctrl_o.memop = MEMOP_SB;
					F3_MEM_H: ctrl_o.memop = MEMOP_SH;
					F3_MEM_W: ctrl_o.memop = MEMOP_SW;
					default:  illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				ctrl_o.rd = X0;
				case (f3)
					F3_BEQ: begin
						ctrl_o.aluop = ALUOP_SUB;
						ctrl_o.branchcond = BCOND_ZERO;
					end
					F3_BNE: begin
						ctrl_o.aluop = ALUOP_SUB;
						ctrl_o.branchcond = BCOND_NZERO;
					end
					F3_BLT: begin
						ctrl_o.aluop = ALUOP_LT;
						ctrl_o.branchcond = BCOND_NZERO;
					end
					F3_BGE: begin
						ctrl_o.aluop = ALUOP_LT;
						ctrl_o.branchcond = BCOND_ZERO;
					end
					F3_BLTU: begin
						ctrl_o.aluop = ALUOP_LTU;
						ctrl_o.branchcond = BCOND_NZERO;
					end
					F3_BGEU: begin
						ctrl_o.aluop = ALUOP_LTU;
						ctrl_o.branchcond = BCOND_ZERO;
					end
					default: illegal = 1'b1;
				endcase
			end
			// jumps compute the link address pc + 4 in the ALU
			OPC_JALR, OPC_JAL: begin
				ctrl_o.rs2 = X0;
				ctrl_o.alusrc_a = ALUSRCA_PC;
				ctrl_o.alusrc_b = ALUSRCB_IMM;
				ctrl_o.imm = XLEN'(4);
				ctrl_o.branchcond = BCOND_ALWAYS;
				if (opc == OPC_JAL) begin
					ctrl_o.rs1 = X0;
				end else begin
					ctrl_o.addr_is_regoffs = 1'b1;
					illegal = illegal || f3 != F3_JALR;
				end
			end
			OPC_LUI, OPC_AUIPC: begin
				ctrl_o.rs1 = X0;
				ctrl_o.rs2 = X0;
				ctrl_o.imm = imm_i.u;
				ctrl_o.alusrc_b = ALUSRCB_IMM;
				if (opc == OPC_LUI) begin
					ctrl_o.aluop = ALUOP_RS2;
				end else begin
					ctrl_o.alusrc_a = ALUSRCA_PC;
				end
			end
			OPC_OP_IMM: begin
				ctrl_o.rs2 = X0;
				ctrl_o.alusrc_b = ALUSRCB_IMM;
				case (f3)
					F3_ADD:  ctrl_o.aluop = ALUOP_ADD;
					F3_SLT:  ctrl_o.aluop = ALUOP_LT;
					F3_SLTU: ctrl_o.aluop = ALUOP_LTU;
					F3_XOR:  ctrl_o.aluop = ALUOP_XOR;
					F3_OR:   ctrl_o.aluop = ALUOP_OR;
					F3_AND:  ctrl_o.aluop = ALUOP_AND;
					F3_SLL: begin
						ctrl_o.aluop = ALUOP_SLL;
						illegal = illegal || f7 != F7_BASE;
					end
					F3_SR: begin
						ctrl_o.aluop = f7 == F7_ALT ? ALUOP_SRA : ALUOP_SRL;
						illegal = illegal || (f7 != F7_BASE && f7 != F7_ALT);
					end
				endcase
			end
			OPC_OP: begin
				if (f7 == F7_ALT) begin
					case (f3)
						F3_ADD:  ctrl_o.aluop = ALUOP_SUB;
						F3_SR:   ctrl_o.aluop = ALUOP_SRA;
						default: illegal = 1'b1;
					endcase
				end else begin
					illegal = illegal || f7 != F7_BASE;
					case (f3)
						F3_ADD:  ctrl_o.aluop = ALUOP_ADD;
						F3_SLL:  ctrl_o.aluop = ALUOP_SLL;
						F3_SLT:  ctrl_o.aluop = ALUOP_LT;
						F3_SLTU: ctrl_o.aluop = ALUOP_LTU;
						F3_XOR:  ctrl_o.aluop = ALUOP_XOR;
						F3_SR:   ctrl_o.aluop = ALUOP_SRL;
						F3_OR:   ctrl_o.aluop = ALUOP_OR;
						F3_AND:  ctrl_o.aluop = ALUOP_AND;
					endcase
				end
			end
			// FENCE is a NOP since a single-issue in-order core has nothing to order
			OPC_MISC_MEM: begin
				ctrl_o.rs1 = X0;
				ctrl_o.rs2 = X0;
				ctrl_o.rd = X0;
				illegal = illegal || f3 != F3_FENCE;
			end
			default: illegal = 1'b1;
		endcase

		// --------------------
		// address offset for jumps, branches and memory accesses

		case (opc)
			OPC_JAL:    ctrl_o.addr_offs = imm_i.j;
			OPC_BRANCH: ctrl_o.addr_offs = imm_i.b;
			OPC_STORE:  ctrl_o.addr_offs = imm_i.s;
			default:    ctrl_o.addr_offs = imm_i.i;
		endcase

		// --------------------
		// a bubble leaves the instruction without side effects in execute
		if (starved_i || illegal || fault) begin
			ctrl_o.rs1 = X0;
			ctrl_o.rs2 = X0;
			ctrl_o.rd = X0;
			ctrl_o.memop = MEMOP_NONE;
			ctrl_o.branchcond = BCOND_NEVER;
			// keeps the data address bus quiet while nothing is issued
			ctrl_o.addr_is_regoffs = 1'b1;
			if (fault) begin
				ctrl_o.except = EXCEPT_INSTR_FAULT;
			end else if (illegal && !starved_i) begin
				ctrl_o.except = EXCEPT_INSTR_ILLEGAL;
			end
		end
	end

endmodule

`default_nettype wire

// ==== pc_ctrl.sv ====
// Decode PC and instruction register control
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl
	import rv_isa_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [1:0]      vld_i,
	input  logic            x_stall_i,
	input  logic            f_jump_now_i,
	input  logic [XLEN-1:0] f_jump_target_i,
	output logic [XLEN-1:0] pc_o,
	output logic [1:0]      cir_use_o,
	output logic            starved_o
);

	logic [XLEN-1:0] pc;
	logic            stalled;

	if (RESET_VECTOR[1:0] != 2'b00) begin : g_bad_reset_vector
		$error("reset vector must be word aligned");
	end

	// every instruction is 32 bits, so both halfwords must be present
	assign starved_o = vld_i < 2'd2;
	assign stalled   = starved_o || x_stall_i;
	assign cir_use_o = stalled ? 2'd0 : 2'd2;
	assign pc_o      = pc;

	// --------------------
	// a redirect from fetch wins over both stall and sequential advance
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_VECTOR;
		end else if (f_jump_now_i) begin
			pc <= f_jump_target_i;
		end else if (!stalled) begin
			pc <= pc + XLEN'(4);
		end
	end

	a_jump_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		f_jump_now_i |-> f_jump_target_i[1:0] == 2'b00);

	// the instruction register holds two halfwords at most
	a_vld_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		vld_i <= 2'd2);

endmodule

`default_nettype wire

// ==== decode_top.sv ====
// RV32I decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_top
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst_n,
	input  fetch_cir_t      cir_i,
	input  logic            x_stall_i,
	input  logic            f_jump_now_i,
	input  logic [XLEN-1:0] f_jump_target_i,
	output d_ctrl_t         ctrl_o,
	output logic [XLEN-1:0] pc_o,
	output logic [1:0]      cir_use_o,
	output logic            starved_o
);

	imm_set_t imm;

	imm_gen imm_gen_i (
		.instr_i (cir_i.instr),
		.imm_o   (imm)
	);

	instr_decoder instr_decoder_i (
		.instr_i   (cir_i.instr),
		.err_i     (cir_i.err),
		.starved_i (starved_o),
		.imm_i     (imm),
		.ctrl_o    (ctrl_o)
	);

	pc_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) pc_ctrl_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.vld_i           (cir_i.vld),
		.x_stall_i       (x_stall_i),
		.f_jump_now_i    (f_jump_now_i),
		.f_jump_target_i (f_jump_target_i),
		.pc_o            (pc_o),
		.cir_use_o       (cir_use_o),
		.starved_o       (starved_o)
	);

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset is released just after an edge, away from the flops' sampling point
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_decode.sv ====
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_decode
	import rv_isa_pkg::*;
	import decode_ctrl_pkg::*;
;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;

	localparam int N_RESET  = 4;
	localparam int N_FLOW   = 200;
	localparam int N_JUMP   = 150;
	localparam int N_IMM    = 300;
	localparam int N_TABLE  = 300;
	localparam int N_EXCEPT = 300;
	localparam int TOTAL_CYCLES = N_RESET + N_FLOW + N_JUMP + N_IMM + N_TABLE + N_EXCEPT;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * 10;

	logic        clk;
	logic        rst_n;
	fetch_cir_t  cir;
	logic        x_stall;
	logic        f_jump_now;
	logic [31:0] f_jump_target;
	d_ctrl_t     ctrl;
	logic [31:0] pc;
	logic [1:0]  cir_use;
	logic        starved;

	integer      seed = 82;
	int          err_count = 0;
	int          pass_count = 0;

	// model state for the pc register and the inputs seen at the last edge
	logic [31:0] exp_pc;
	logic        cur_jump;
	logic [31:0] cur_target;
	logic        cur_stalled;

	// format instructions: load, store, branch, jal, jalr, lui, auipc
	int fmt_kinds [7] = '{0, 1, 2, 3, 4, 7, 8};

	tb_clk_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (3)
	) clk_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	decode_top #(
		.RESET_VECTOR (RESET_VECTOR)
	) dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.cir_i           (cir),
		.x_stall_i       (x_stall),
		.f_jump_now_i    (f_jump_now),
		.f_jump_target_i (f_jump_target),
		.ctrl_o          (ctrl),
		.pc_o            (pc),
		.cir_use_o       (cir_use),
		.starved_o       (starved)
	);

	// --------------------
	// checking

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			err_count = err_count + 1;
		end else begin
			pass_count = pass_count + 1;
		end
	endtask

	// bubble fields and except are always known, the rest only for a real instruction
	task automatic check_ctrl(input d_ctrl_t got, input d_ctrl_t exp, input logic full);
		check_val("ctrl_o.rs1", 32'(got.rs1), 32'(exp.rs1));
		check_val("ctrl_o.rs2", 32'(got.rs2), 32'(exp.rs2));
		check_val("ctrl_o.rd", 32'(got.rd), 32'(exp.rd));
		check_val("ctrl_o.memop", 32'(got.memop), 32'(exp.memop));
		check_val("ctrl_o.branchcond", 32'(got.branchcond), 32'(exp.branchcond));
		check_val("ctrl_o.addr_is_regoffs", 32'(got.addr_is_regoffs),
			32'(exp.addr_is_regoffs));
		check_val("ctrl_o.except", 32'(got.except), 32'(exp.except));
		if (full) begin
			check_val("ctrl_o.imm", got.imm, exp.imm);
			check_val("ctrl_o.addr_offs", got.addr_offs, exp.addr_offs);
			check_val("ctrl_o.alusrc_a", 32'(got.alusrc_a), 32'(exp.alusrc_a));
			check_val("ctrl_o.alusrc_b", 32'(got.alusrc_b), 32'(exp.alusrc_b));
			check_val("ctrl_o.aluop", 32'(got.aluop), 32'(exp.aluop));
			check_val("ctrl_o.funct3", 32'(got.funct3), 32'(exp.funct3));
		end
	endtask

	task automatic report_test(input string name, input int start_errs);
		$display("%s: %0d errors", name, err_count - start_errs);
	endtask

	// --------------------
	// reference model

	function automatic logic legal_instr(input instr_t w);
		logic [4:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ok;
		opc = w[6:2];
		f3 = w[14:12];
		f7 = w[31:25];
		case (opc)
			OPC_LOAD:                     ok = f3 != 3'd3 && f3 < 3'd6;
			OPC_STORE:                    ok = f3 <= 3'd2;
			OPC_BRANCH:                   ok = f3[2:1] != 2'b01;
			OPC_JALR, OPC_MISC_MEM:       ok = f3 == 3'd0;
			OPC_JAL, OPC_LUI, OPC_AUIPC:  ok = 1'b1;
			OPC_OP_IMM: begin
				if (f3 == 3'd1)
					ok = f7 == 7'h00;
				else if (f3 == 3'd5)
					ok = f7 == 7'h00 || f7 == 7'h20;
				else
					ok = 1'b1;
			end
			OPC_OP:  ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			default: ok = 1'b0;
		endcase
		return ok && w[1:0] == 2'b11;
	endfunction

	function automatic aluop_e alu_for(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return alt ? ALUOP_SUB : ALUOP_ADD;
			3'd1:    return ALUOP_SLL;
			3'd2:    return ALUOP_LT;
			3'd3:    return ALUOP_LTU;
			3'd4:    return ALUOP_XOR;
			3'd5:    return alt ? ALUOP_SRA : ALUOP_SRL;
			3'd6:    return ALUOP_OR;
			default: return ALUOP_AND;
		endcase
	endfunction

	task automatic model_ctrl(input instr_t w, input logic [1:0] vld, input logic [1:0] err,
		output d_ctrl_t c, output logic bubble);
		logic [4:0]  opc;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        is_starved;
		logic        fault;
		logic        legal;
		opc = w[6:2];
		f3 = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

		c.rs1 = w[19:15];
		c.rs2 = w[24:20];
		c.rd = w[11:7];
		c.imm = imm_i;
		c.alusrc_a = ALUSRCA_RS1;
		c.alusrc_b = ALUSRCB_RS2;
		c.aluop = ALUOP_ADD;
		c.memop = MEMOP_NONE;
		c.branchcond = BCOND_NEVER;
		c.addr_offs = imm_i;
		c.addr_is_regoffs = 1'b0;
		c.except = EXCEPT_NONE;
		c.funct3 = f3;

		case (opc)
			OPC_LOAD: begin
				c.rs2 = '0;
				c.addr_is_regoffs = 1'b1;
				case (f3)
					3'd0:    c.memop = MEMOP_LB;
					3'd1:    c.memop = MEMOP_LH;
					3'd2:    c.memop = MEMOP_LW;
					3'd4:    c.memop = MEMOP_LBU;
					default: c.memop = MEMOP_LHU;
				endcase
			end
			OPC_STORE: begin
				c.rd = '0;
				c.addr_is_regoffs = 1'b1;
				c.aluop = ALUOP_RS2;
				c.addr_offs = imm_s;
				case (f3)
					3'd0:    c.memop = MEMOP_SB;
					3'd1:    c.memop = MEMOP_SH;
					default: c.memop = MEMOP_SW;
				endcase
			end
			OPC_BRANCH: begin
				c.rd = '0;
				c.addr_offs = imm_b;
				case (f3[2:1])
					2'b00:   c.aluop = ALUOP_SUB;
					2'b10:   c.aluop = ALUOP_LT;
					default: c.aluop = ALUOP_LTU;
				endcase
				// eq and ge take the branch on a zero compare result
				c.branchcond = (f3[0] ^ f3[2]) ? BCOND_NZERO : BCOND_ZERO;
			end
			OPC_JAL, OPC_JALR: begin
				c.rs2 = '0;
				c.alusrc_a = ALUSRCA_PC;
				c.alusrc_b = ALUSRCB_IMM;
				c.imm = 32'd4;
				c.branchcond = BCOND_ALWAYS;
				if (opc == OPC_JAL) begin
					c.rs1 = '0;
					c.addr_offs = imm_j;
				end else begin
					c.addr_is_regoffs = 1'b1;
				end
			end
			OPC_LUI, OPC_AUIPC: begin
				c.rs1 = '0;
				c.rs2 = '0;
				c.imm = imm_u;
				c.alusrc_b = ALUSRCB_IMM;
				if (opc == OPC_LUI)
					c.aluop = ALUOP_RS2;
				else
					c.alusrc_a = ALUSRCA_PC;
			end
			OPC_OP_IMM: begin
				c.rs2 = '0;
				c.alusrc_b = ALUSRCB_IMM;
				c.aluop = alu_for(f3, f3 == 3'd5 && w[30]);
			end
			OPC_OP: c.aluop = alu_for(f3, w[30]);
			OPC_MISC_MEM: begin
				c.rs1 = '0;
				c.rs2 = '0;
				c.rd = '0;
			end
			default: ;
		endcase

		is_starved = vld < 2'd2;
		fault = !is_starved && err != 2'b00;
		legal = legal_instr(w);
		bubble = is_starved || fault || !legal;
		if (bubble) begin
			c.rs1 = '0;
			c.rs2 = '0;
			c.rd = '0;
			c.memop = MEMOP_NONE;
			c.branchcond = BCOND_NEVER;
			c.addr_is_regoffs = 1'b1;
			if (fault)
				c.except = EXCEPT_INSTR_FAULT;
			else if (!is_starved)
				c.except = EXCEPT_INSTR_ILLEGAL;
		end
	endtask

	// --------------------
	// stimulus

	// kinds 0 to 9: load store branch jal jalr op-imm op lui auipc fence
	task automatic gen_legal(input int kind, output instr_t w);
		logic [2:0] f3;
		logic [4:0] opc;
		int         n;
		w = $random(seed);
		f3 = w[14:12];
		case (kind)
			0: begin
				opc = OPC_LOAD;
				n = {$random(seed)} % 5;
				f3 = 3'(n < 3 ? n : n + 1);
			end
			1: begin
				opc = OPC_STORE;
				f3 = 3'({$random(seed)} % 3);
			end
			2: begin
				opc = OPC_BRANCH;
				n = {$random(seed)} % 6;
				f3 = 3'(n < 2 ? n : n + 2);
			end
			3: opc = OPC_JAL;
			4: begin
				opc = OPC_JALR;
				f3 = 3'd0;
			end
			5: begin
				opc = OPC_OP_IMM;
				if (f3 == 3'd1)
					w[31:25] = 7'h00;
				else if (f3 == 3'd5)
					w[31:25] = {1'b0, w[30], 5'b00000};
			end
			6: begin
				opc = OPC_OP;
				if (f3 == 3'd0 || f3 == 3'd5)
					w[31:25] = {1'b0, w[30], 5'b00000};
				else
					w[31:25] = 7'h00;
			end
			7: opc = OPC_LUI;
			8: opc = OPC_AUIPC;
			default: begin
				opc = OPC_MISC_MEM;
				f3 = 3'd0;
			end
		endcase
		w[14:12] = f3;
		w[6:0] = {opc, 2'b11};
	endtask

	// one cycle: inputs change 1 ns after the edge, outputs are checked mid-cycle
	task automatic step(input instr_t w, input logic [1:0] vld, input logic [1:0] err,
		input logic stall, input logic jump, input logic [31:0] target);
		d_ctrl_t exp_ctrl;
		logic    bubble;
		@(posedge clk);
		if (cur_jump)
			exp_pc = cur_target;
		else if (!cur_stalled)
			exp_pc = exp_pc + 32'd4;
		#1;
		cir.instr = w;
		cir.vld = vld;
		cir.err = err;
		x_stall = stall;
		f_jump_now = jump;
		f_jump_target = target;
		cur_jump = jump;
		cur_target = target;
		cur_stalled = vld < 2'd2 || stall;
		model_ctrl(w, vld, err, exp_ctrl, bubble);
		#4;
		check_val("pc_o", pc, exp_pc);
		check_val("cir_use_o", 32'(cir_use), cur_stalled ? 32'd0 : 32'd2);
		check_val("starved_o", 32'(starved), 32'(vld < 2'd2));
		check_ctrl(ctrl, exp_ctrl, !bubble);
	endtask

	// a quarter of the cycles leave the instruction register short of a word
	task automatic pick_vld(output logic [1:0] vld);
		if ({$random(seed)} % 4 == 0)
			vld = 2'({$random(seed)} % 2);
		else
			vld = 2'd2;
	endtask

	task automatic run_reset_test();
		int start;
		start = err_count;
		@(posedge rst_n);
		#1;
		check_val("pc_o", pc, RESET_VECTOR);
		check_val("starved_o", 32'(starved), 32'd1);
		check_val("cir_use_o", 32'(cir_use), 32'd0);
		check_val("ctrl_o.except", 32'(ctrl.except), 32'(EXCEPT_NONE));
		report_test("reset", start);
	endtask

	task automatic run_flow_test();
		int         start;
		instr_t     w;
		logic [1:0] vld;
		integer     r;
		start = err_count;
		for (int i = 0; i < N_FLOW; i++) begin
			gen_legal({$random(seed)} % 10, w);
			pick_vld(vld);
			r = $random(seed);
			step(w, vld, 2'b00, r[0], 1'b0, 32'd0);
		end
		report_test("sequential flow and stall", start);
	endtask

	task automatic run_jump_test();
		int         start;
		instr_t     w;
		logic [1:0] vld;
		integer     r;
		integer     t;
		start = err_count;
		for (int i = 0; i < N_JUMP; i++) begin
			gen_legal({$random(seed)} % 10, w);
			pick_vld(vld);
			r = $random(seed);
			t = $random(seed);
			step(w, vld, 2'b00, r[0], r[3:2] == 2'b00, {t[31:2], 2'b00});
		end
		report_test("jump redirect", start);
	endtask

	task automatic run_imm_test();
		int     start;
		instr_t w;
		start = err_count;
		for (int i = 0; i < N_IMM; i++) begin
			gen_legal(fmt_kinds[{$random(seed)} % 7], w);
			step(w, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0);
		end
		report_test("immediates and offsets", start);
	endtask

	task automatic run_table_test();
		int     start;
		instr_t w;
		integer r;
		start = err_count;
		for (int i = 0; i < N_TABLE; i++) begin
			gen_legal({$random(seed)} % 10, w);
			r = $random(seed);
			step(w, 2'd2, 2'b00, r[1:0] == 2'b00, 1'b0, 32'd0);
		end
		report_test("control table", start);
	endtask

	task automatic run_except_test();
		int         start;
		instr_t     w;
		integer     r;
		logic [1:0] err;
		start = err_count;
		for (int i = 0; i < N_EXCEPT; i++) begin
			r = $random(seed);
			err = 2'(1 + {$random(seed)} % 3);
			case ({$random(seed)} % 4)
				0: step(r, 2'd2, 2'b00, 1'b0, 1'b0, 32'd0);
				// mostly illegal words, the fault must still win
				1: step(r, 2'd2, err, 1'b0, 1'b0, 32'd0);
				2: begin
					gen_legal({$random(seed)} % 10, w);
					step(w, 2'd2, err, 1'b0, 1'b0, 32'd0);
				end
				default: step(r, 2'({$random(seed)} % 2), 2'(r[9:8]), 1'b0, 1'b0, 32'd0);
			endcase
		end
		report_test("exceptions", start);
	endtask

	// --------------------
	// main sequence

	initial begin
		cir = '0;
		x_stall = 1'b0;
		f_jump_now = 1'b0;
		f_jump_target = 32'd0;
		exp_pc = RESET_VECTOR;
		cur_jump = 1'b0;
		cur_target = 32'd0;
		cur_stalled = 1'b1;

		run_reset_test();
		run_flow_test();
		run_jump_test();
		run_imm_test();
		run_table_test();
		run_except_test();

		$display("checks passed %0d, errors %0d", pass_count, err_count);
		if (err_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rv_isa_pkg.sv
decode_ctrl_pkg.sv
imm_gen.sv
instr_decoder.sv
pc_ctrl.sv
decode_top.sv
tb_clk_gen.sv
tb_decode.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_decode -f verilog.f
./obj_dir/Vtb_decode | tee sim.log
if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
